// ==== Bender.yml ====
package:
  name: reorder_bridge

export_include_dirs:
  - hdl

sources:
  - include_dirs:
      - hdl
    files:
      - hdl/tl_msg_pkg.sv
      - hdl/reorder_pkg.sv
      - hdl/req_tagger.sv
      - hdl/rsp_store.sv
      - hdl/in_order_drain.sv
      - hdl/reorder_top.sv
  - target: test
    include_dirs:
      - hdl
    files:
      - verif/reorder_chk.sv
      - verif/reorder_tb.sv

// ==== hdl/in_order_drain.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "reorder_defines.svh"

module in_order_drain (
  input  wire logic                                             clk_i,
  input  wire logic                                             rst_ni,

  input  wire logic [reorder_pkg::num_slots-1:0]                slot_busy_i,
  input  wire logic [reorder_pkg::num_slots-1:0][`RO_HSRC_W-1:0] slot_source_i,
  input  wire logic [reorder_pkg::num_slots-1:0]                slot_done_i,
  input  wire logic [reorder_pkg::num_slots-1:0][`RO_OP_W-1:0]  slot_opcode_i,
  input  wire logic [reorder_pkg::num_slots-1:0][`RO_DATA_W-1:0] slot_data_i,
  input  wire logic [reorder_pkg::num_slots-1:0]                slot_denied_i,

  output logic                                                  rel_valid_o,
  output logic [`RO_SLOT_W-1:0]                                 rel_idx_o,

  output logic                                                  host_d_valid_o,
  input  wire logic                                             host_d_ready_i,
  output logic [`RO_OP_W-1:0]                                   host_d_opcode_o,
  output logic [`RO_HSRC_W-1:0]                                 host_d_source_o,
  output logic [`RO_DATA_W-1:0]                                 host_d_data_o,
  output logic                                                  host_d_denied_o
);

  logic [`RO_SLOT_W-1:0] head_q;
  logic                  d_valid_q;
  logic                  head_ready;
  logic                  slice_free;
  logic                  load;

  // Head slot holds a finished answer and the slice can take it.
  assign head_ready = slot_busy_i[head_q] && slot_done_i[head_q];
  assign slice_free = !d_valid_q || host_d_ready_i;
  assign load       = head_ready && slice_free;

  // Loading the slice frees the head slot on both sides.
  assign rel_valid_o = load;
  assign rel_idx_o   = head_q;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      head_q    <= '0;
      d_valid_q <= 1'b0;
    end else if (load) begin
      head_q    <= reorder_pkg::next_slot(head_q);
      d_valid_q <= 1'b1;
    end else if (host_d_ready_i) begin
      d_valid_q <= 1'b0;
    end
  end

  // Host D slice. AccessAck carries no data, so zero it.
  always_ff @(posedge clk_i) begin
    if (load) begin
      host_d_opcode_o <= slot_opcode_i[head_q];
      host_d_source_o <= slot_source_i[head_q];
      host_d_denied_o <= slot_denied_i[head_q];
      if (slot_opcode_i[head_q] == tl_msg_pkg::d_access_ack) begin
        host_d_data_o <= '0;
      end else begin
        host_d_data_o <= slot_data_i[head_q];
      end
    end
  end

  assign host_d_valid_o = d_valid_q;

endmodule

`default_nettype wire

// ==== hdl/reorder_defines.svh ====
`ifndef REORDER_DEFINES_SVH
`define REORDER_DEFINES_SVH

////////////////////
// Link widths
////////////////////

// Data width of host and device links.
`define RO_DATA_W 32

// Address width of channel A.
`define RO_ADDR_W 16

// Source ID width on the host side.
`define RO_HSRC_W 4

// Tracker slot index, also used as device source.
`define RO_SLOT_W 2

// Opcode width on channels A and D.
`define RO_OP_W 3

`endif

// ==== hdl/reorder_pkg.sv ====
`default_nettype none

`include "reorder_defines.svh"

package reorder_pkg;

  // Number of tracker slots.
  localparam int unsigned num_slots = 2 ** `RO_SLOT_W;

  // Index of the last slot, where the pointers wrap.
  localparam logic [`RO_SLOT_W-1:0] last_slot = `RO_SLOT_W'(num_slots - 1);

  // Step a slot pointer, wrapping back to slot zero.
  function automatic logic [`RO_SLOT_W-1:0] next_slot(input logic [`RO_SLOT_W-1:0] idx);
    logic [`RO_SLOT_W-1:0] nxt;
    if (idx == last_slot) begin
      nxt = '0;
    end else begin
      nxt = idx + 1'b1;
    end
    return nxt;
  endfunction

endpackage

`default_nettype wire

// ==== hdl/reorder_top.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "reorder_defines.svh"

module reorder_top (
  input  wire logic                   clk_i,
  input  wire logic                   rst_ni,

  input  wire logic                   host_a_valid_i,
  output logic                        host_a_ready_o,
  input  wire logic [`RO_OP_W-1:0]    host_a_opcode_i,
  input  wire logic [`RO_HSRC_W-1:0]  host_a_source_i,
  input  wire logic [`RO_ADDR_W-1:0]  host_a_address_i,
  input  wire logic [`RO_DATA_W-1:0]  host_a_data_i,

  output logic                        device_a_valid_o,
  input  wire logic                   device_a_ready_i,
  output logic [`RO_OP_W-1:0]         device_a_opcode_o,
  output logic [`RO_SLOT_W-1:0]       device_a_source_o,
  output logic [`RO_ADDR_W-1:0]       device_a_address_o,
  output logic [`RO_DATA_W-1:0]       device_a_data_o,

  input  wire logic                   device_d_valid_i,
  input  wire logic [`RO_OP_W-1:0]    device_d_opcode_i,
  input  wire logic [`RO_SLOT_W-1:0]  device_d_source_i,
  input  wire logic [`RO_DATA_W-1:0]  device_d_data_i,
  input  wire logic                   device_d_denied_i,

  output logic                        host_d_valid_o,
  input  wire logic                   host_d_ready_i,
  output logic [`RO_OP_W-1:0]         host_d_opcode_o,
  output logic [`RO_HSRC_W-1:0]       host_d_source_o,
  output logic [`RO_DATA_W-1:0]       host_d_data_o,
  output logic                        host_d_denied_o
);

  // Tagger side of each slot.
  logic [reorder_pkg::num_slots-1:0]                  slot_busy;
  logic [reorder_pkg::num_slots-1:0][`RO_HSRC_W-1:0]  slot_source;

  // Store side of each slot.
  logic [reorder_pkg::num_slots-1:0]                  slot_done;
  logic [reorder_pkg::num_slots-1:0][`RO_OP_W-1:0]    slot_opcode;
  logic [reorder_pkg::num_slots-1:0][`RO_DATA_W-1:0]  slot_data;
  logic [reorder_pkg::num_slots-1:0]                  slot_denied;

  // Head release from the drain.
  logic                   rel_valid;
  logic [`RO_SLOT_W-1:0]  rel_idx;

  req_tagger req_tagger_i (
    .clk_i              (clk_i),
    .rst_ni             (rst_ni),
    .host_a_valid_i     (host_a_valid_i),
    .host_a_ready_o     (host_a_ready_o),
    .host_a_opcode_i    (host_a_opcode_i),
    .host_a_source_i    (host_a_source_i),
    .host_a_address_i   (host_a_address_i),
    .host_a_data_i      (host_a_data_i),
    .device_a_valid_o   (device_a_valid_o),
    .device_a_ready_i   (device_a_ready_i),
    .device_a_opcode_o  (device_a_opcode_o),
    .device_a_source_o  (device_a_source_o),
    .device_a_address_o (device_a_address_o),
    .device_a_data_o    (device_a_data_o),
    .rel_valid_i        (rel_valid),
    .rel_idx_i          (rel_idx),
    .slot_busy_o        (slot_busy),
    .slot_source_o      (slot_source)
  );

  rsp_store rsp_store_i (
    .clk_i             (clk_i),
    .rst_ni            (rst_ni),
    .device_d_valid_i  (device_d_valid_i),
    .device_d_opcode_i (device_d_opcode_i),
    .device_d_source_i (device_d_source_i),
    .device_d_data_i   (device_d_data_i),
    .device_d_denied_i (device_d_denied_i),
    .rel_valid_i       (rel_valid),
    .rel_idx_i         (rel_idx),
    .slot_done_o       (slot_done),
    .slot_opcode_o     (slot_opcode),
    .slot_data_o       (slot_data),
    .slot_denied_o     (slot_denied)
  );

  in_order_drain in_order_drain_i (
    .clk_i           (clk_i),
    .rst_ni          (rst_ni),
    .slot_busy_i     (slot_busy),
    .slot_source_i   (slot_source),
    .slot_done_i     (slot_done),
    .slot_opcode_i   (slot_opcode),
    .slot_data_i     (slot_data),
    .slot_denied_i   (slot_denied),
    .rel_valid_o     (rel_valid),
    .rel_idx_o       (rel_idx),
    .host_d_valid_o  (host_d_valid_o),
    .host_d_ready_i  (host_d_ready_i),
    .host_d_opcode_o (host_d_opcode_o),
    .host_d_source_o (host_d_source_o),
    .host_d_data_o   (host_d_data_o),
    .host_d_denied_o (host_d_denied_o)
  );

endmodule

`default_nettype wire

// ==== hdl/req_tagger.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "reorder_defines.svh"

module req_tagger (
  input  wire logic                                               clk_i,
  input  wire logic                                               rst_ni,

  input  wire logic                                               host_a_valid_i,
  output logic                                                    host_a_ready_o,
  input  wire logic [`RO_OP_W-1:0]                                host_a_opcode_i,
  input  wire logic [`RO_HSRC_W-1:0]                              host_a_source_i,
  input  wire logic [`RO_ADDR_W-1:0]                              host_a_address_i,
  input  wire logic [`RO_DATA_W-1:0]                              host_a_data_i,

  output logic                                                    device_a_valid_o,
  input  wire logic                                               device_a_ready_i,
  output logic [`RO_OP_W-1:0]                                     device_a_opcode_o,
  output logic [`RO_SLOT_W-1:0]                                   device_a_source_o,
  output logic [`RO_ADDR_W-1:0]                                   device_a_address_o,
  output logic [`RO_DATA_W-1:0]                                   device_a_data_o,

  input  wire logic                                               rel_valid_i,
  input  wire logic [`RO_SLOT_W-1:0]                              rel_idx_i,
  output logic [reorder_pkg::num_slots-1:0]                       slot_busy_o,
  output logic [reorder_pkg::num_slots-1:0][`RO_HSRC_W-1:0]       slot_source_o
);

  logic [`RO_SLOT_W-1:0]                              alloc_q;
  logic [reorder_pkg::num_slots-1:0]                  busy_q;
  logic [reorder_pkg::num_slots-1:0][`RO_HSRC_W-1:0]  source_q;
  logic                                               slot_free;
  logic                                               accept;

  // A request may only pass when the slot in turn is free.
  assign slot_free        = !busy_q[alloc_q];
  assign host_a_ready_o   = device_a_ready_i && slot_free;
  assign device_a_valid_o = host_a_valid_i && slot_free;
  assign accept           = host_a_valid_i && host_a_ready_o;

  // Forward the request, tagged with the slot number.
  assign device_a_opcode_o  = host_a_opcode_i;
  assign device_a_source_o  = alloc_q;
  assign device_a_address_o = host_a_address_i;
  assign device_a_data_o    = host_a_data_i;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      alloc_q <= '0;
      busy_q  <= '0;
    end else begin
      if (rel_valid_i) begin
        busy_q[rel_idx_i] <= 1'b0;
      end
      if (accept) begin
        busy_q[alloc_q] <= 1'b1;
        alloc_q         <= reorder_pkg::next_slot(alloc_q);
      end
    end
  end

  // Host source kept until the answer goes back.
  always_ff @(posedge clk_i) begin
    if (accept) begin
      source_q[alloc_q] <= host_a_source_i;
    end
  end

  assign slot_busy_o   = busy_q;
  assign slot_source_o = source_q;

endmodule

`default_nettype wire

// ==== hdl/rsp_store.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "reorder_defines.svh"

module rsp_store (
  input  wire logic                                             clk_i,
  input  wire logic                                             rst_ni,

  input  wire logic                                             device_d_valid_i,
  input  wire logic [`RO_OP_W-1:0]                              device_d_opcode_i,
  input  wire logic [`RO_SLOT_W-1:0]                            device_d_source_i,
  input  wire logic [`RO_DATA_W-1:0]                            device_d_data_i,
  input  wire logic                                             device_d_denied_i,

  input  wire logic                                             rel_valid_i,
  input  wire logic [`RO_SLOT_W-1:0]                            rel_idx_i,

  output logic [reorder_pkg::num_slots-1:0]                     slot_done_o,
  output logic [reorder_pkg::num_slots-1:0][`RO_OP_W-1:0]       slot_opcode_o,
  output logic [reorder_pkg::num_slots-1:0][`RO_DATA_W-1:0]     slot_data_o,
  output logic [reorder_pkg::num_slots-1:0]                     slot_denied_o
);

  logic [reorder_pkg::num_slots-1:0]                  done_q;
  logic [reorder_pkg::num_slots-1:0][`RO_OP_W-1:0]    opcode_q;
  logic [reorder_pkg::num_slots-1:0][`RO_DATA_W-1:0]  data_q;
  logic [reorder_pkg::num_slots-1:0]                  denied_q;

  ////////////////////
  // Arrival flags
  ////////////////////

  // A slot is released only after its answer has come in, so the
  // write and the release never name the same slot in one cycle.
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      done_q <= '0;
    end else begin
      if (rel_valid_i) begin
        done_q[rel_idx_i] <= 1'b0;
      end
      if (device_d_valid_i) begin
        done_q[device_d_source_i] <= 1'b1;
      end
    end
  end

  ////////////////////
  // Response fields
  ////////////////////

  always_ff @(posedge clk_i) begin
    if (device_d_valid_i) begin
      opcode_q[device_d_source_i] <= device_d_opcode_i;
      data_q[device_d_source_i]   <= device_d_data_i;
      denied_q[device_d_source_i] <= device_d_denied_i;
    end
  end

  assign slot_done_o   = done_q;
  assign slot_opcode_o = opcode_q;
  assign slot_data_o   = data_q;
  assign slot_denied_o = denied_q;

endmodule

`default_nettype wire

// ==== hdl/tl_msg_pkg.sv ====
`default_nettype none

`include "reorder_defines.svh"

package tl_msg_pkg;

  // Channel A request opcodes.
  localparam logic [`RO_OP_W-1:0] a_put_full = `RO_OP_W'(0);
  localparam logic [`RO_OP_W-1:0] a_get      = `RO_OP_W'(4);

  // Channel D response opcodes.
  localparam logic [`RO_OP_W-1:0] d_access_ack      = `RO_OP_W'(0);
  localparam logic [`RO_OP_W-1:0] d_access_ack_data = `RO_OP_W'(1);

  // Response opcode that answers a given request opcode.
  // Only Get carries data back.
  function automatic logic [`RO_OP_W-1:0] d_opcode_for(input logic [`RO_OP_W-1:0] a_op);
    logic [`RO_OP_W-1:0] d_op;
    d_op = d_access_ack;
    if (a_op == a_get) begin
      d_op = d_access_ack_data;
    end
    return d_op;
  endfunction

endpackage

`default_nettype wire

// ==== project.f ====
+incdir+hdl
hdl/tl_msg_pkg.sv
hdl/reorder_pkg.sv
hdl/req_tagger.sv
hdl/rsp_store.sv
hdl/in_order_drain.sv
hdl/reorder_top.sv
verif/reorder_chk.sv
verif/reorder_tb.sv

// ==== verif/reorder_chk.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "reorder_defines.svh"

module reorder_chk (
  input wire logic                   clk_i,
  input wire logic                   rst_ni,
  input wire logic                   host_d_valid_i,
  input wire logic                   host_d_ready_i,
  input wire logic [`RO_OP_W-1:0]    host_d_opcode_i,
  input wire logic [`RO_HSRC_W-1:0]  host_d_source_i,
  input wire logic [`RO_DATA_W-1:0]  host_d_data_i,
  input wire logic                   host_d_denied_i,
  input wire logic                   device_a_valid_i,
  input wire logic                   device_a_ready_i,
  input wire logic [`RO_OP_W-1:0]    device_a_opcode_i,
  input wire logic [`RO_SLOT_W-1:0]  device_a_source_i,
  input wire logic [`RO_ADDR_W-1:0]  device_a_address_i,
  input wire logic [`RO_DATA_W-1:0]  device_a_data_i
);

  // Number of assertion failures so far.
  int unsigned n_fail = 0;

  // Host D beat holds while the host stalls.
  host_d_stable: assert property (@(posedge clk_i) disable iff (!rst_ni)
    host_d_valid_i && !host_d_ready_i |=> host_d_valid_i &&
      $stable({host_d_opcode_i, host_d_source_i, host_d_data_i, host_d_denied_i}))
    else begin
      $error("Host D beat changed while stalled.");
      n_fail++;
    end

  // Device A request holds until the device takes it.
  device_a_stable: assert property (@(posedge clk_i) disable iff (!rst_ni)
    device_a_valid_i && !device_a_ready_i |=> device_a_valid_i &&
      $stable({device_a_opcode_i, device_a_source_i, device_a_address_i, device_a_data_i}))
    else begin
      $error("Device A request changed before acceptance.");
      n_fail++;
    end

  host_d_idle_in_reset: assert property (@(posedge clk_i) !rst_ni |-> !host_d_valid_i)
    else begin
      $error("Host D valid during reset.");
      n_fail++;
    end

endmodule

bind reorder_top reorder_chk reorder_chk_i (
  .clk_i              (clk_i),
  .rst_ni             (rst_ni),
  .host_d_valid_i     (host_d_valid_o),
  .host_d_ready_i     (host_d_ready_i),
  .host_d_opcode_i    (host_d_opcode_o),
  .host_d_source_i    (host_d_source_o),
  .host_d_data_i      (host_d_data_o),
  .host_d_denied_i    (host_d_denied_o),
  .device_a_valid_i   (device_a_valid_o),
  .device_a_ready_i   (device_a_ready_i),
  .device_a_opcode_i  (device_a_opcode_o),
  .device_a_source_i  (device_a_source_o),
  .device_a_address_i (device_a_address_o),
  .device_a_data_i    (device_a_data_o)
);

`default_nettype wire

// ==== verif/reorder_tb.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "reorder_defines.svh"

module reorder_tb;

  localparam int unsigned num_reqs   = 300;
  localparam int unsigned idle_limit = 2000;

  logic                   clk_i;
  logic                   rst_ni;
  logic                   host_a_valid_i;
  logic                   host_a_ready_o;
  logic [`RO_OP_W-1:0]    host_a_opcode_i;
  logic [`RO_HSRC_W-1:0]  host_a_source_i;
  logic [`RO_ADDR_W-1:0]  host_a_address_i;
  logic [`RO_DATA_W-1:0]  host_a_data_i;
  logic                   device_a_valid_o;
  logic                   device_a_ready_i;
  logic [`RO_OP_W-1:0]    device_a_opcode_o;
  logic [`RO_SLOT_W-1:0]  device_a_source_o;
  logic [`RO_ADDR_W-1:0]  device_a_address_o;
  logic [`RO_DATA_W-1:0]  device_a_data_o;
  logic                   device_d_valid_i;
  logic [`RO_OP_W-1:0]    device_d_opcode_i;
  logic [`RO_SLOT_W-1:0]  device_d_source_i;
  logic [`RO_DATA_W-1:0]  device_d_data_i;
  logic                   device_d_denied_i;
  logic                   host_d_valid_o;
  logic                   host_d_ready_i;
  logic [`RO_OP_W-1:0]    host_d_opcode_o;
  logic [`RO_HSRC_W-1:0]  host_d_source_o;
  logic [`RO_DATA_W-1:0]  host_d_data_o;
  logic                   host_d_denied_o;

  integer seed = 70;

  // Device model: sparse memory and one pending answer per device source.
  logic [`RO_DATA_W-1:0]  dev_mem [logic [`RO_ADDR_W-1:0]];
  logic                   pend     [reorder_pkg::num_slots];
  int unsigned            wait_cnt [reorder_pkg::num_slots];
  logic [`RO_OP_W-1:0]    rsp_op   [reorder_pkg::num_slots];
  logic [`RO_DATA_W-1:0]  rsp_data [reorder_pkg::num_slots];
  logic                   rsp_den  [reorder_pkg::num_slots];

  // Reference model: its own memory and the responses expected in request order.
  logic [`RO_DATA_W-1:0]  ref_mem [logic [`RO_ADDR_W-1:0]];
  logic [`RO_OP_W-1:0]    exp_op_q[$];
  logic [`RO_HSRC_W-1:0]  exp_src_q[$];
  logic [`RO_DATA_W-1:0]  exp_data_q[$];
  logic                   exp_den_q[$];

  logic        directed;
  logic        a_fired;
  int unsigned n_issued;
  int unsigned n_accepted;
  int unsigned n_returned;
  int unsigned gap;
  int unsigned stall;
  int unsigned idle;

  reorder_top reorder_top_i (.*);

  always #4 clk_i = ~clk_i;

  function automatic int unsigned rand_below(input int unsigned n);
    return $unsigned($random(seed)) % n;
  endfunction

  ////////////////////
  // Failure reporting
  ////////////////////

  task automatic fail_run(input string line);
    $display("%s", line);
    $display("ERRORS FOUND");
    $fatal(1, "Simulation stopped.");
  endtask

  task automatic report_mismatch(input string msg);
    fail_run($sformatf("Mismatch at %0t ns: %s", $time, msg));
  endtask

  task automatic check_opcode(input logic [`RO_OP_W-1:0] act, input logic [`RO_OP_W-1:0] exp);
    if (act !== exp) begin
      report_mismatch($sformatf("host_d_opcode_o is %0h, expected %0h", act, exp));
    end
  endtask

  task automatic check_source(input logic [`RO_HSRC_W-1:0] act,
                              input logic [`RO_HSRC_W-1:0] exp);
    if (act !== exp) begin
      report_mismatch($sformatf("host_d_source_o is %0h, expected %0h", act, exp));
    end
  endtask

  task automatic check_data(input logic [`RO_DATA_W-1:0] act,
                            input logic [`RO_DATA_W-1:0] exp);
    if (act !== exp) begin
      report_mismatch($sformatf("host_d_data_o is %0h, expected %0h", act, exp));
    end
  endtask

  task automatic check_denied(input logic act, input logic exp);
    if (act !== exp) begin
      report_mismatch($sformatf("host_d_denied_o is %0b, expected %0b", act, exp));
    end
  endtask

  // Handshake levels such as ready and valid.
  task automatic check_level(input logic act, input logic exp, input string name);
    if (act !== exp) begin
      report_mismatch($sformatf("%s is %0b, expected %0b", name, act, exp));
    end
  endtask

  // Failures counted by the bound checker.
  task automatic check_assertions();
    if (reorder_top_i.reorder_chk_i.n_fail != 0) begin
      fail_run("An assertion in the bound checker failed.");
    end
  endtask

  ////////////////////
  // Per-cycle models
  ////////////////////

  // Runs in the rising edge time step, before any DUT register updates.
  task automatic sample_edge();
    logic                  den;
    logic [`RO_DATA_W-1:0] rd;
    if (directed && host_a_valid_i) begin
      check_level(host_a_ready_o, n_accepted < reorder_pkg::num_slots, "host_a_ready_o");
    end
    if (host_a_valid_i && host_a_ready_o) begin
      den = host_a_address_i[`RO_ADDR_W-1];
      rd  = '0;
      if (host_a_opcode_i == tl_msg_pkg::a_get && !den && ref_mem.exists(host_a_address_i)) begin
        rd = ref_mem[host_a_address_i];
      end
      if (host_a_opcode_i == tl_msg_pkg::a_put_full && !den) begin
        ref_mem[host_a_address_i] = host_a_data_i;
      end
      exp_op_q.push_back(tl_msg_pkg::d_opcode_for(host_a_opcode_i));
      exp_src_q.push_back(host_a_source_i);
      exp_data_q.push_back(rd);
      exp_den_q.push_back(den);
      n_accepted++;
      a_fired = 1'b1;
    end
    if (device_a_valid_o && device_a_ready_i) begin
      if (pend[device_a_source_o]) begin
        fail_run("Device A reused a source that was still outstanding.");
      end
      den = device_a_address_o[`RO_ADDR_W-1];
      rd  = '0;
      if (device_a_opcode_o == tl_msg_pkg::a_put_full && !den) begin
        dev_mem[device_a_address_o] = device_a_data_o;
      end
      if (device_a_opcode_o == tl_msg_pkg::a_get && !den &&
          dev_mem.exists(device_a_address_o)) begin
        rd = dev_mem[device_a_address_o];
      end
      pend[device_a_source_o]     = 1'b1;
      wait_cnt[device_a_source_o] = rand_below(16);
      rsp_op[device_a_source_o]   = (device_a_opcode_o == tl_msg_pkg::a_get) ?
                                    tl_msg_pkg::d_access_ack_data : tl_msg_pkg::d_access_ack;
      rsp_data[device_a_source_o] = rd;
      // Junk on the data lines of an AccessAck, which the bridge must drop.
      if (device_a_opcode_o == tl_msg_pkg::a_put_full) begin
        rsp_data[device_a_source_o] = $random(seed);
      end
      rsp_den[device_a_source_o]  = den;
    end
    if (host_d_valid_o && host_d_ready_i) begin
      if (exp_op_q.size() == 0) begin
        fail_run("Host D returned a response that no request asked for.");
      end else begin
        check_opcode(host_d_opcode_o, exp_op_q.pop_front());
        check_source(host_d_source_o, exp_src_q.pop_front());
        check_data(host_d_data_o, exp_data_q.pop_front());
        check_denied(host_d_denied_o, exp_den_q.pop_front());
        n_returned++;
        idle = 0;
      end
    end
  endtask

  // Runs on the falling edge.
  task automatic drive_inputs();
    int unsigned first;
    int unsigned idx;
    int unsigned k;
    device_d_valid_i = 1'b0;
    if (!directed) begin
      // Answer one ripe request, starting the search at a random slot.
      first = rand_below(reorder_pkg::num_slots);
      for (k = 0; k < reorder_pkg::num_slots; k++) begin
        idx = (first + k) % reorder_pkg::num_slots;
        if (pend[idx] && wait_cnt[idx] == 0 && !device_d_valid_i) begin
          device_d_valid_i  = 1'b1;
          device_d_source_i = `RO_SLOT_W'(idx);
          device_d_opcode_i = rsp_op[idx];
          device_d_data_i   = rsp_data[idx];
          device_d_denied_i = rsp_den[idx];
          pend[idx]         = 1'b0;
        end else if (pend[idx] && wait_cnt[idx] != 0) begin
          wait_cnt[idx]--;
        end
      end
    end
    if (a_fired) begin
      host_a_valid_i = 1'b0;
      a_fired        = 1'b0;
      gap            = directed ? 0 : rand_below(4);
    end
    if (!host_a_valid_i && n_issued < num_reqs) begin
      if (gap == 0) begin
        host_a_valid_i   = 1'b1;
        host_a_opcode_i  = rand_below(2) ? tl_msg_pkg::a_get : tl_msg_pkg::a_put_full;
        host_a_source_i  = `RO_HSRC_W'(rand_below(16));
        host_a_address_i = `RO_ADDR_W'(rand_below(16));
        host_a_address_i[`RO_ADDR_W-1] = (rand_below(8) == 0);
        host_a_data_i    = $random(seed);
        n_issued++;
      end else begin
        gap--;
      end
    end
    // Host D stalls now and then for a long stretch.
    if (directed) begin
      device_a_ready_i = 1'b1;
      host_d_ready_i   = 1'b0;
    end else begin
      device_a_ready_i = (rand_below(4) != 0);
      if (stall != 0) begin
        stall--;
        host_d_ready_i = 1'b0;
      end else if (rand_below(64) == 0) begin
        stall          = 20 + rand_below(30);
        host_d_ready_i = 1'b0;
      end else begin
        host_d_ready_i = (rand_below(4) != 0);
      end
    end
  endtask

  task automatic run_cycle();
    drive_inputs();
    @(posedge clk_i);
    sample_edge();
    @(negedge clk_i);
    check_assertions();
  endtask

  initial begin
    clk_i             = 1'b0;
    rst_ni            = 1'b1;
    host_a_valid_i    = 1'b0;
    host_a_opcode_i   = '0;
    host_a_source_i   = '0;
    host_a_address_i  = '0;
    host_a_data_i     = '0;
    device_a_ready_i  = 1'b0;
    device_d_valid_i  = 1'b0;
    device_d_opcode_i = '0;
    device_d_source_i = '0;
    device_d_data_i   = '0;
    device_d_denied_i = 1'b0;
    host_d_ready_i    = 1'b0;
    for (int s = 0; s < reorder_pkg::num_slots; s++) begin
      pend[s] = 1'b0;
    end
    directed   = 1'b1;
    a_fired    = 1'b0;
    n_issued   = 0;
    n_accepted = 0;
    n_returned = 0;
    gap        = 0;
    stall      = 0;
    idle       = 0;

    // Reset falls before the first rising edge.
    #1;
    rst_ni = 1'b0;
    repeat (3) @(posedge clk_i);
    @(negedge clk_i);
    rst_ni = 1'b1;
    check_assertions();
    check_level(host_d_valid_o, 1'b0, "host_d_valid_o");
    check_level(device_a_valid_o, 1'b0, "device_a_valid_o");

    // Four requests fill every slot, then the fifth waits.
    repeat (7) run_cycle();
    directed = 1'b0;

    while (n_returned < num_reqs) begin
      run_cycle();
      idle++;
      if (idle > idle_limit) begin
        fail_run("Timeout: the next host D response did not arrive.");
      end
    end

    if (exp_op_q.size() == 0 && n_accepted == num_reqs) begin
      $display("NO ERRORS");
      $finish;
    end else begin
      fail_run("Accepted requests and returned responses do not match.");
    end
  end

endmodule

`default_nettype wire
